//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_hart
LOG       ?= sim.log
FLAGS     ?= --binary --assert
RUN_FLAGS ?= +verilator+error+limit+1000
OBJ_DIR   ?= obj_dir
FILELIST  := verilog.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/decoder.sv
module decoder (
    input  logic [rv_pkg::XLEN-1:0] i_inst,
    output rv_pkg::ctrl_t           o_ctrl
);
    import rv_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;  // Selects sub and sra
    alu_op_e    arith_op;   // Shared by OP and OP_IMM

    assign opcode    = opcode_e'(i_inst[6:0]);
    assign funct3    = i_inst[14:12];
    assign funct7_b5 = i_inst[30];

    // ALU operation from funct3
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;  // No subi
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;  // Shifts honor bit 30 in both
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    ////////////////////
    // Main decode
    ////////////////////
    always_comb begin
        o_ctrl          = '0;        // Unknown opcode acts as a no-op
        o_ctrl.op_a_sel = OPA_RS1;
        o_ctrl.alu_op   = ALU_ADD;   // Address add for loads and stores
        o_ctrl.br_cond  = BR_EQ;
        o_ctrl.imm_fmt  = IMM_I;
        case (opcode)
            OPC_OP: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_op    = arith_op;
            end
            OPC_OP_IMM: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.alu_op      = arith_op;
            end
            OPC_LOAD: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.mem_read    = 1'b1;
                o_ctrl.mem_to_reg  = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
            end
            OPC_STORE: begin
                o_ctrl.mem_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.imm_fmt     = IMM_S;
            end
            OPC_BRANCH: begin
                // funct3 010 and 011 are reserved, never taken
                o_ctrl.is_branch   = (funct3[2:1] != 2'b01);
                o_ctrl.br_cond     = br_cond_e'({funct3[2], funct3[0]});
                o_ctrl.br_unsigned = funct3[1];
                o_ctrl.imm_fmt     = IMM_B;
            end
            OPC_LUI: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.op_a_sel    = OPA_ZERO;
                o_ctrl.alu_op      = ALU_PASS_B;
                o_ctrl.imm_fmt     = IMM_U;
            end
            OPC_AUIPC: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.op_a_sel    = OPA_PC;  // PC + upper immediate
                o_ctrl.imm_fmt     = IMM_U;
            end
            default: ;
        endcase
    end

endmodule

//--- rtl/execute.sv
module execute (
    input  rv_pkg::ctrl_t           i_ctrl,
    input  logic [rv_pkg::XLEN-1:0] i_pc,
    input  logic [rv_pkg::XLEN-1:0] i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0] i_rs2_data,
    input  logic [rv_pkg::XLEN-1:0] i_imm,
    input  logic [rv_pkg::XLEN-1:0] i_dmem_rdata,
    output rv_pkg::dmem_req_t       o_dmem_req,
    output logic [rv_pkg::XLEN-1:0] o_wb_data,
    output logic                    o_branch_taken
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic [4:0]      shamt;
    logic            eq;
    logic            lt;
    logic            cond_met;

    ////////////////////
    // Operands
    ////////////////////
    always_comb begin
        case (i_ctrl.op_a_sel)
            OPA_ZERO: op_a = '0;    // LUI
            OPA_PC:   op_a = i_pc;  // AUIPC
            default:  op_a = i_rs1_data;
        endcase
    end

    assign op_b  = i_ctrl.alu_src_imm ? i_imm : i_rs2_data;
    assign shamt = op_b[4:0];

    ////////////////////
    // ALU
    ////////////////////
    always_comb begin
        case (i_ctrl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_res = XLEN'(op_a < op_b);
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // Branch compare on rs1 vs rs2
    assign eq = (op_a == op_b);
    assign lt = i_ctrl.br_unsigned ? (op_a < op_b) : ($signed(op_a) < $signed(op_b));

    always_comb begin
        case (i_ctrl.br_cond)
            BR_EQ:   cond_met = eq;
            BR_NE:   cond_met = !eq;
            BR_LT:   cond_met = lt;
            default: cond_met = !lt;  // BR_GE
        endcase
    end

    assign o_branch_taken = i_ctrl.is_branch && cond_met;

    // Word accesses only, address straight from the adder
    assign o_dmem_req.addr  = alu_res;
    assign o_dmem_req.wdata = i_rs2_data;
    assign o_dmem_req.ren   = i_ctrl.mem_read;
    assign o_dmem_req.wen   = i_ctrl.mem_write;

    assign o_wb_data = i_ctrl.mem_to_reg ? i_dmem_rdata : alu_res;  // Load or ALU

endmodule

//--- rtl/fetch_pc.sv
module fetch_pc #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_ADDR = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_branch_taken,  // From execute, same cycle
    input  logic [rv_pkg::XLEN-1:0] i_imm,           // B-immediate of current inst
    output logic [rv_pkg::XLEN-1:0] o_pc
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc_next;

    // Target is relative to the PC of the branch itself
    assign pc_next = i_branch_taken ? (o_pc + i_imm)
                                    : (o_pc + XLEN'(4));  // Sequential

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_pc <= RESET_ADDR;
        end else begin
            o_pc <= pc_next;
        end
    end

endmodule

//--- rtl/hart_top.sv
module hart_top #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_ADDR = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [rv_pkg::XLEN-1:0] o_imem_raddr,
    input  logic [rv_pkg::XLEN-1:0] i_imem_rdata,   // Same-cycle instruction
    output rv_pkg::dmem_req_t       o_dmem_req,
    input  logic [rv_pkg::XLEN-1:0] i_dmem_rdata    // Same-cycle load data
);
    import rv_pkg::*;

    logic [XLEN-1:0]       pc;
    ctrl_t                 ctrl;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       wb_data;
    logic                  branch_taken;

    // Register fields sit at fixed positions in every format
    assign rs1_addr = i_imem_rdata[19:15];
    assign rs2_addr = i_imem_rdata[24:20];
    assign rd_addr  = i_imem_rdata[11:7];

    assign o_imem_raddr = pc;

    fetch_pc #(.RESET_ADDR(RESET_ADDR)) fetch_pc_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_branch_taken (branch_taken),
        .i_imm          (imm),
        .o_pc           (pc)
    );

    decoder decoder_inst (
        .i_inst (i_imem_rdata),
        .o_ctrl (ctrl)
    );

    imm_gen imm_gen_inst (
        .i_inst (i_imem_rdata),
        .i_fmt  (ctrl.imm_fmt),
        .o_imm  (imm)
    );

    reg_file reg_file_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_rd_addr  (rd_addr),
        .i_rd_wen   (ctrl.reg_write),
        .i_rd_wdata (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    execute execute_inst (
        .i_ctrl         (ctrl),
        .i_pc           (pc),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .i_imm          (imm),
        .i_dmem_rdata   (i_dmem_rdata),
        .o_dmem_req     (o_dmem_req),
        .o_wb_data      (wb_data),
        .o_branch_taken (branch_taken)
    );

endmodule

//--- rtl/imm_gen.sv
module imm_gen (
    input  logic [rv_pkg::XLEN-1:0] i_inst,
    input  rv_pkg::imm_fmt_e        i_fmt,
    output logic [rv_pkg::XLEN-1:0] o_imm
);
    import rv_pkg::*;

    logic sign;  // Bit 31 is the sign for every format

    assign sign = i_inst[31];

    always_comb begin
        case (i_fmt)
            IMM_S: begin
                o_imm = {{20{sign}}, i_inst[31:25], i_inst[11:7]};
            end
            IMM_B: begin
                // Halfword offset, low bit implied zero
                o_imm = {{19{sign}}, sign, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
            end
            IMM_U: begin
                o_imm = {i_inst[31:12], 12'b0};  // Upper 20 bits
            end
            default: begin
                o_imm = {{20{sign}}, i_inst[31:20]};  // I format
            end
        endcase
    end

endmodule

//--- rtl/reg_file.sv
module reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd_addr,
    input  logic                          i_rd_wen,
    input  logic [rv_pkg::XLEN-1:0]       i_rd_wdata,
    output logic [rv_pkg::XLEN-1:0]       o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]       o_rs2_data
);

    localparam int DATA_W = $bits(i_rd_wdata);
    localparam int NREGS  = 2 ** $bits(i_rd_addr);

    logic [DATA_W-1:0] regs [1:NREGS-1];  // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && (i_rd_addr != '0)) begin  // Drop writes to x0
            regs[i_rd_addr] <= i_rd_wdata;
        end
    end

    // Combinational reads, x0 always zero
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

//--- rtl/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;  // Data and address width
    localparam int REG_ADDR_W = 5;   // 32 architectural registers

    ////////////////////
    // Encodings
    ////////////////////

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b011_0011,  // R-type ALU
        OPC_OP_IMM = 7'b001_0011,  // I-type ALU
        OPC_LOAD   = 7'b000_0011,  // lw only
        OPC_STORE  = 7'b010_0011,  // sw only
        OPC_BRANCH = 7'b110_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_AUIPC  = 7'b001_0111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_PASS_B                     // LUI, operand B straight through
    } alu_op_e;

    // Order matches {funct3[2], funct3[0]} of the branch encodings
    typedef enum logic [1:0] {BR_EQ, BR_NE, BR_LT, BR_GE} br_cond_e;

    typedef enum logic [1:0] {IMM_I, IMM_S, IMM_B, IMM_U} imm_fmt_e;

    typedef enum logic [1:0] {OPA_RS1, OPA_ZERO, OPA_PC} op_a_sel_e;

    ////////////////////
    // Bundles
    ////////////////////

    typedef struct packed {
        logic      reg_write;    // Write rd at end of cycle
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;   // Writeback from load data
        logic      alu_src_imm;  // Operand B is the immediate
        op_a_sel_e op_a_sel;
        alu_op_e   alu_op;
        logic      is_branch;
        br_cond_e  br_cond;
        logic      br_unsigned;  // bltu / bgeu
        imm_fmt_e  imm_fmt;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            ren;
        logic            wen;
    } dmem_req_t;

endpackage

//--- verif/hart_assert.sv
module hart_assert #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_ADDR = '0
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic [rv_pkg::XLEN-1:0] i_pc,        // Fetch address
    input logic [rv_pkg::XLEN-1:0] i_inst,      // Fetched word
    input rv_pkg::dmem_req_t       i_dmem_req
);
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    int unsigned fail_count = 0;  // Read by the testbench at the end

    ////////////////////
    // Fetch side
    ////////////////////

    // First fetch after reset comes from the reset vector
    reset_vector: assert property (@(posedge clk) $rose(rst_n) |-> (i_pc == RESET_ADDR))
        else begin
            $error("first fetch after reset is not at the reset address");
            fail_count++;
        end

    pc_sequential: assert property (@(posedge clk) disable iff (!rst_n)
        (i_inst[6:0] != OPC_BRANCH) |=> (i_pc == $past(i_pc) + XLEN'(4)))  // Non-branch steps by 4
        else begin
            $error("next fetch address after a non-branch is not PC + 4");
            fail_count++;
        end

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) i_pc[1:0] == 2'b00)
        else begin
            $error("fetch address is not word aligned");
            fail_count++;
        end

    ////////////////////
    // Data port
    ////////////////////
    dmem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_dmem_req.ren && i_dmem_req.wen))
        else begin
            $error("data read and write enables both high");
            fail_count++;
        end

    dmem_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (i_dmem_req.ren || i_dmem_req.wen) |-> (i_dmem_req.addr[1:0] == 2'b00))
        else begin
            $error("data access address is not word aligned");
            fail_count++;
        end

endmodule

//--- verif/tb_hart.sv
module tb_hart;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam logic [31:0] RESET_ADDR   = 32'h0000_0400;
    localparam logic [31:0] FAIL_ADDR    = 32'h0000_00f8;  // Program stores test number here
    localparam logic [31:0] DONE_ADDR    = 32'h0000_00fc;
    localparam int          RESET_CYCLES = 10;
    localparam logic [31:0] VA = 32'h8765_4321;  // Negative, large unsigned
    localparam logic [31:0] VB = 32'h0000_0005;  // Small positive, also shift amount
    localparam logic [31:0] VC = 32'h1234_5678;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] imem_raddr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_rdata;
    dmem_req_t   dmem_req;
    logic [31:0] imem [512];
    logic [31:0] dmem [64];
    int          wp;                // Next free instruction slot
    int          test_no;
    int          limit;
    int          assert_fails;
    int          cycles = 0;
    int          errors = 0;
    logic        done = 1'b0;
    logic        timed_out = 1'b0;

    always #4 clk = ~clk;

    hart_top #(.RESET_ADDR(RESET_ADDR)) hart_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .o_imem_raddr (imem_raddr),
        .i_imem_rdata (imem_rdata),
        .o_dmem_req   (dmem_req),
        .i_dmem_rdata (dmem_rdata)
    );

    bind hart_top hart_assert #(.RESET_ADDR(RESET_ADDR)) hart_assert_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_pc       (o_imem_raddr),
        .i_inst     (i_imem_rdata),
        .i_dmem_req (o_dmem_req)
    );

    // Both memories answer within the cycle
    assign imem_rdata = imem[9'((imem_raddr - RESET_ADDR) >> 2)];
    assign dmem_rdata = dmem_req.ren ? dmem[dmem_req.addr[7:2]] : 32'hbad0_bad0;  // Junk unless read

    // Store model plus done and fail watch
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst_n && dmem_req.wen) begin
            dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
            if (dmem_req.addr == DONE_ADDR && dmem_req.wdata == 32'd1) begin
                done <= 1'b1;
            end
            assert (dmem_req.addr != FAIL_ADDR) else begin
                $display("CHECK FAILED at %0t: program test %0d mismatched",
                         $time, dmem_req.wdata);
                errors <= errors + 1;
            end
        end
    end

    ////////////////////
    // Instruction encoders
    ////////////////////
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};  // sw
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    ////////////////////
    // Program builders
    ////////////////////
    task automatic emit(input logic [31:0] word);
        imem[wp] = word;
        wp++;
    endtask

    // lui + addi, upper part corrected for the sign of the low 12 bits
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] lo;
        lo = {{20{value[11]}}, value[11:0]};
        emit(u_type(20'((value - lo) >> 12), rd, 7'h37));
        emit(i_type(value[11:0], rd, 3'b000, rd, 7'h13));
    endtask

    task automatic fail_store();
        emit(i_type(12'(test_no), 5'd0, 3'b000, 5'd30, 7'h13));
        emit(s_type(FAIL_ADDR[11:0], 5'd30, 5'd0));
    endtask

    // Taken branch hops over the fail store
    task automatic expect_taken(input logic [2:0] f3, input logic [4:0] rs1,
                                input logic [4:0] rs2);
        test_no++;
        emit(b_type(13'd12, rs2, rs1, f3));
        fail_store();
    endtask

    // Falls through to a skip, a wrong take lands on the fail store
    task automatic expect_not_taken(input logic [2:0] f3, input logic [4:0] rs1,
                                    input logic [4:0] rs2);
        test_no++;
        emit(b_type(13'd8, rs2, rs1, f3));
        emit(b_type(13'd12, 5'd0, 5'd0, 3'b000));
        fail_store();
    endtask

    task automatic check_reg(input logic [4:0] rd, input logic [31:0] expected);
        load_const(5'd31, expected);
        expect_taken(3'b000, rd, 5'd31);  // beq rd, x31
    endtask

    task automatic alu_rr(input logic [2:0] f3, input logic [6:0] f7, input logic [4:0] rs1,
                          input logic [4:0] rs2, input logic [31:0] expected);
        emit(r_type(f7, rs2, rs1, f3, 5'd10));
        check_reg(5'd10, expected);
    endtask

    task automatic alu_ri(input logic [2:0] f3, input logic [11:0] imm, input logic [4:0] rs1,
                          input logic [31:0] expected);
        emit(i_type(imm, rs1, f3, 5'd10, 7'h13));
        check_reg(5'd10, expected);
    endtask

    task automatic build_program();
        logic [31:0] auipc_pc;
        wp      = 0;
        test_no = 0;
        load_const(5'd1, VA);
        load_const(5'd2, VB);
        load_const(5'd3, VC);
        load_const(5'd4, 32'h0000_0020);  // Base for a non-zero-base access
        alu_rr(3'b000, 7'h00, 5'd1, 5'd3, VA + VC);
        alu_rr(3'b000, 7'h20, 5'd1, 5'd3, VA - VC);
        alu_rr(3'b001, 7'h00, 5'd3, 5'd2, VC << 5);
        alu_rr(3'b010, 7'h00, 5'd1, 5'd2, 32'd1);  // Negative below positive
        alu_rr(3'b010, 7'h00, 5'd2, 5'd1, 32'd0);
        alu_rr(3'b011, 7'h00, 5'd1, 5'd2, 32'd0);  // Unsigned view flips it
        alu_rr(3'b011, 7'h00, 5'd2, 5'd1, 32'd1);
        alu_rr(3'b100, 7'h00, 5'd1, 5'd3, VA ^ VC);
        alu_rr(3'b101, 7'h00, 5'd1, 5'd2, VA >> 5);
        alu_rr(3'b101, 7'h20, 5'd1, 5'd2, 32'hfc3b_2a19);  // Sign fills from the left
        alu_rr(3'b101, 7'h20, 5'd3, 5'd2, VC >> 5);
        alu_rr(3'b110, 7'h00, 5'd1, 5'd3, VA | VC);
        alu_rr(3'b111, 7'h00, 5'd1, 5'd3, VA & VC);
        alu_ri(3'b000, 12'hfff, 5'd1, VA - 32'd1);  // Bit 30 set, still an add
        alu_ri(3'b011, 12'hfff, 5'd2, 32'd1);
        alu_ri(3'b110, 12'h700, 5'd3, VC | 32'h700);
        alu_ri(3'b001, 12'h004, 5'd3, VC << 4);
        alu_ri(3'b101, 12'h408, 5'd1, 32'hff87_6543);  // srai by 8
        emit(u_type(20'habcde, 5'd10, 7'h37));
        check_reg(5'd10, 32'habcd_e000);
        auipc_pc = RESET_ADDR + 32'(wp) * 32'd4;
        emit(u_type(20'h00001, 5'd10, 7'h17));
        check_reg(5'd10, auipc_pc + 32'h0000_1000);
        emit(s_type(12'h010, 5'd3, 5'd0));
        emit(i_type(12'h010, 5'd0, 3'b010, 5'd10, 7'h03));
        check_reg(5'd10, VC);
        emit(s_type(12'h014, 5'd1, 5'd0));
        emit(s_type(12'h014, 5'd0, 5'd0));  // Overwrite with x0
        emit(i_type(12'h014, 5'd0, 3'b010, 5'd10, 7'h03));
        check_reg(5'd10, 32'd0);
        emit(s_type(12'h008, 5'd1, 5'd4));
        emit(i_type(12'h008, 5'd4, 3'b010, 5'd10, 7'h03));
        check_reg(5'd10, VA);
        expect_taken(3'b000, 5'd1, 5'd1);
        expect_not_taken(3'b000, 5'd1, 5'd2);
        expect_taken(3'b001, 5'd1, 5'd2);
        expect_not_taken(3'b001, 5'd1, 5'd1);
        expect_taken(3'b100, 5'd1, 5'd2);
        expect_not_taken(3'b100, 5'd2, 5'd1);
        expect_taken(3'b101, 5'd2, 5'd1);
        expect_not_taken(3'b101, 5'd1, 5'd2);
        expect_taken(3'b110, 5'd2, 5'd1);
        expect_not_taken(3'b110, 5'd1, 5'd2);
        expect_taken(3'b111, 5'd1, 5'd2);
        expect_not_taken(3'b111, 5'd2, 5'd1);
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd30, 7'h13));
        emit(s_type(DONE_ADDR[11:0], 5'd30, 5'd0));
        emit(b_type(13'd0, 5'd0, 5'd0, 3'b000));  // Park here
    endtask

    initial begin
        rst_n = 1'b0;
        build_program();
        limit = RESET_CYCLES + 4 * wp;  // Straight-line program, generous margin
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        while (!done && cycles < limit) begin
            @(posedge clk);
        end
        if (!done) begin
            $display("timeout: program never reached the done store");
            timed_out = 1'b1;
        end
        repeat (2) @(posedge clk);
        assert_fails = hart_top_inst.hart_assert_inst.fail_count;
        $display("errors: %0d program, %0d assertion, %0d timeout",
                 errors, assert_fails, timed_out);
        if (errors == 0 && assert_fails == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/rv_pkg.sv
rtl/fetch_pc.sv
rtl/decoder.sv
rtl/imm_gen.sv
rtl/reg_file.sv
rtl/execute.sv
rtl/hart_top.sv
verif/hart_assert.sv
verif/tb_hart.sv
